/* common/tlbPkg.sv */
package tlbPkg;

	// ====================
	// TLB geometry
	// ====================
	localparam int SETS = 16;
	localparam int WAYS = 4;
	localparam int SET_W = $clog2(SETS);
	localparam int WAY_W = $clog2(WAYS);
	localparam int ENTRIES = SETS * WAYS;

	// Address fields for fixed 8 KB pages
	localparam int VA_W = 32;
	localparam int PA_W = 32;
	localparam int OFFSET_W = 13;
	localparam int VPN_W = VA_W - OFFSET_W;
	localparam int PFN_W = PA_W - OFFSET_W;
	localparam int TAG_W = VPN_W - SET_W;
	localparam int ASID_W = 8;

	// Top address byte of the unmapped region
	localparam logic [7:0] UNMAPPED_HI = 8'hFF;

	// Frame number handed back on a miss
	localparam logic [PFN_W-1:0] MISS_PFN = '1;

	// ====================
	// Entry types
	// ====================
	typedef struct packed {
		logic [TAG_W-1:0] tag;
		logic [ASID_W-1:0] asid;
		logic isGlobal;
	} tlbTag_t;

	typedef struct packed {
		logic [PFN_W-1:0] pfn;
		logic rd;
		logic wr;
		logic ex;
		logic uncached;
	} tlbData_t;

	// Way in the upper bits, set in the lower bits
	typedef struct packed {
		logic [WAY_W-1:0] way;
		logic [SET_W-1:0] set;
	} entryIdx_t;

endpackage

/* common/mmuRegPkg.sv */
package mmuRegPkg;

	localparam int DATA_W = 32;

	// ====================
	// Command codes
	// ====================
	typedef enum logic [3:0] {
		OP_NOP       = 4'd0,
		OP_READ      = 4'd1,
		OP_WRITE_IDX = 4'd2,
		OP_WRITE_RND = 4'd3,
		OP_ENABLE    = 4'd4,
		OP_DISABLE   = 4'd5,
		OP_RDREG     = 4'd6,
		OP_WRREG     = 4'd7,
		OP_INVALL    = 4'd8
	} tlbOp_t;

	// ====================
	// Register numbers
	// ====================
	typedef enum logic [2:0] {
		REG_WIRED    = 3'd0,
		REG_INDEX    = 3'd1,
		REG_RANDOM   = 3'd2,
		REG_VIRTPAGE = 3'd3,
		REG_PHYSPAGE = 3'd4,
		REG_MISC     = 3'd5,
		REG_MISSADDR = 3'd6
	} tlbReg_t;

	// Misc register layout
	localparam int MISC_X = 0;
	localparam int MISC_W = 1;
	localparam int MISC_R = 2;
	localparam int MISC_UNCACHED = 3;
	localparam int MISC_GLOBAL = 4;
	localparam int MISC_VALID = 5;
	localparam int MISC_ASID_LSB = 8;

endpackage

/* tlb/tlbEntryRam.sv */
`timescale 1ns/1ps

module tlbEntryRam #(
	parameter type payload_t = logic [7:0]
) (
	input  logic                     clk,
	input  logic                     wrEn_i,
	input  logic [tlbPkg::SET_W-1:0] wrSet_i,
	input  payload_t                 wrData_i,
	input  logic [tlbPkg::SET_W-1:0] rdSet0_i,
	output payload_t                 rdData0_o,
	input  logic [tlbPkg::SET_W-1:0] rdSet1_i,
	output payload_t                 rdData1_o
);

	import tlbPkg::*;

	// One way, one word per set
	payload_t mem [SETS];

	always_ff @(posedge clk)
	begin
		if (wrEn_i)
			mem[wrSet_i] <= wrData_i;
	end

	// Port 0 serves maintenance reads, port 1 the translation path
	assign rdData0_o = mem[rdSet0_i];
	assign rdData1_o = mem[rdSet1_i];

endmodule

/* tlb/tlbLookup.sv */
`timescale 1ns/1ps

module tlbLookup (
	input  logic                       clk,
	input  logic                       reset_i,
	input  logic                       reqValid_i,
	input  logic [tlbPkg::VA_W-1:0]    vadr_i,
	input  logic                       reqWrite_i,
	input  logic                       reqExec_i,
	input  logic [tlbPkg::ASID_W-1:0]  asid_i,
	input  logic [1:0]                 opLevel_i,
	input  logic                       tlbEnabled_i,
	input  logic [tlbPkg::ENTRIES-1:0] valid_i,
	input  tlbPkg::tlbTag_t            tags_i [tlbPkg::WAYS],
	input  tlbPkg::tlbData_t           data_i [tlbPkg::WAYS],
	output logic [tlbPkg::SET_W-1:0]   lookupSet_o,
	output logic                       rspValid_o,
	output logic [tlbPkg::PA_W-1:0]    padr_o,
	output logic                       miss_o,
	output logic                       rdViol_o,
	output logic                       wrViol_o,
	output logic                       exViol_o,
	output logic                       uncached_o,
	output logic                       missPulse_o,
	output logic [tlbPkg::VA_W-1:0]    missVadr_o
);

	import tlbPkg::*;

	logic [SET_W-1:0] reqSet;
	logic [TAG_W-1:0] reqTag;
	logic [WAYS-1:0] wayMatch;
	logic [WAY_W-1:0] hitWay;
	logic hitFound;
	logic mapped;
	logic missNow;
	tlbData_t hitData;

	assign reqSet = vadr_i[OFFSET_W +: SET_W];
	assign reqTag = vadr_i[VA_W-1 -: TAG_W];
	assign lookupSet_o = reqSet;

	// Off, level 0 and the top region all pass the address through
	assign mapped = tlbEnabled_i && (opLevel_i != 2'd0)
		&& (vadr_i[VA_W-1 -: 8] != UNMAPPED_HI);

	// ====================
	// Way compare
	// ====================
	always_comb
	begin
		entryIdx_t idx;
		for (int w = 0; w < WAYS; w++)
		begin
			idx = '{way: WAY_W'(w), set: reqSet};
			wayMatch[w] = valid_i[idx] && (tags_i[w].tag == reqTag)
				&& ((tags_i[w].asid == asid_i) || tags_i[w].isGlobal);
		end
	end

	// Lowest matching way wins
	always_comb
	begin
		hitFound = 1'b0;
		hitWay = '0;
		for (int w = WAYS - 1; w >= 0; w--)
		begin
			if (wayMatch[w])
			begin
				hitFound = 1'b1;
				hitWay = WAY_W'(w);
			end
		end
	end

	assign hitData = data_i[hitWay];
	assign missNow = mapped && !hitFound;

	// First-miss capture happens in control on the same edge
	assign missPulse_o = reqValid_i && missNow;
	assign missVadr_o = vadr_i;

	// ====================
	// Response stage
	// ====================
	always_ff @(posedge clk)
	begin
		if (reset_i)
		begin
			rspValid_o <= 1'b0;
			miss_o <= 1'b0;
			rdViol_o <= 1'b0;
			wrViol_o <= 1'b0;
			exViol_o <= 1'b0;
			uncached_o <= 1'b0;
		end
		else
		begin
			rspValid_o <= reqValid_i;
			miss_o <= reqValid_i && missNow;
			// Permission flags only for a mapped hit
			wrViol_o <= reqValid_i && mapped && hitFound && reqWrite_i && !hitData.wr;
			exViol_o <= reqValid_i && mapped && hitFound && reqExec_i && !hitData.ex;
			rdViol_o <= reqValid_i && mapped && hitFound && !reqWrite_i && !reqExec_i
				&& !hitData.rd;
			uncached_o <= reqValid_i && mapped && hitFound && hitData.uncached;
		end
	end

	always_ff @(posedge clk)
	begin
		if (!mapped)
			padr_o <= vadr_i;
		else if (hitFound)
			padr_o <= {hitData.pfn, vadr_i[OFFSET_W-1:0]};
		else
			padr_o <= {MISS_PFN, vadr_i[OFFSET_W-1:0]};
	end

endmodule

/* tlb/tlbControl.sv */
`timescale 1ns/1ps

module tlbControl (
	input  logic                          clk,
	input  logic                          reset_i,
	input  logic                          ld_i,
	input  mmuRegPkg::tlbOp_t             op_i,
	input  mmuRegPkg::tlbReg_t            regNo_i,
	input  logic [mmuRegPkg::DATA_W-1:0]  dataIn_i,
	output logic                          done_o,
	output logic                          idle_o,
	output logic [mmuRegPkg::DATA_W-1:0]  dataOut_o,
	output logic                          tlbEnabled_o,
	output logic [tlbPkg::ENTRIES-1:0]    valid_o,
	output logic [tlbPkg::WAYS-1:0]       entWrEn_o,
	output logic [tlbPkg::SET_W-1:0]      entWrSet_o,
	output tlbPkg::tlbTag_t               entWrTag_o,
	output tlbPkg::tlbData_t              entWrData_o,
	output logic [tlbPkg::SET_W-1:0]      entRdSet_o,
	input  tlbPkg::tlbTag_t               rdTags_i [tlbPkg::WAYS],
	input  tlbPkg::tlbData_t              rdData_i [tlbPkg::WAYS],
	input  logic                          missPulse_i,
	input  logic [tlbPkg::VA_W-1:0]       missVadr_i
);

	import tlbPkg::*;
	import mmuRegPkg::*;

	typedef enum logic [1:0] {IDLE, ONE, TWO} ctlState_t;

	ctlState_t state;

	// Latched command
	tlbOp_t opReg;
	tlbReg_t regReg;
	logic [DATA_W-1:0] dataReg;

	// Holding registers
	logic [VPN_W-1:0] hVirtPage;
	logic [PFN_W-1:0] hPhysPage;
	logic [ASID_W-1:0] hAsid;
	logic hGlobal;
	logic hValid;
	logic hRead;
	logic hWrite;
	logic hExec;
	logic hUncached;

	logic [WAY_W-1:0] wiredReg;
	logic [WAY_W-1:0] indexReg;
	logic [WAY_W-1:0] randomReg;
	logic tlbEnabled;
	logic [ENTRIES-1:0] validVec;
	logic [VA_W-1:0] missAddr;
	entryIdx_t entIdx;
	logic isWrite;
	logic regWrite;
	logic [DATA_W-1:0] miscWord;

	assign done_o = (state == TWO);
	assign idle_o = (state == IDLE);
	assign tlbEnabled_o = tlbEnabled;
	assign valid_o = validVec;

	assign isWrite = (opReg == OP_WRITE_IDX) || (opReg == OP_WRITE_RND);
	assign regWrite = (state == ONE) && (opReg == OP_WRREG);

	// ====================
	// Command sequencing
	// ====================
	always_ff @(posedge clk)
	begin
		if (reset_i)
			state <= IDLE;
		else
		begin
			case (state)
				IDLE:
					if (ld_i)
						state <= ONE;
				ONE:
					state <= TWO;
				default:
					state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == IDLE && ld_i)
		begin
			opReg <= op_i;
			regReg <= regNo_i;
			dataReg <= dataIn_i;
		end
	end

	// Entry index is fixed in ONE and used in TWO
	always_ff @(posedge clk)
	begin
		if (state == ONE)
		begin
			if (opReg == OP_WRITE_RND)
				entIdx <= '{way: randomReg, set: hVirtPage[SET_W-1:0]};
			else
				entIdx <= '{way: indexReg, set: hVirtPage[SET_W-1:0]};
		end
	end

	// ====================
	// Control registers
	// ====================
	always_ff @(posedge clk)
	begin
		if (reset_i)
		begin
			tlbEnabled <= 1'b0;
			validVec <= '0;
			wiredReg <= '0;
			indexReg <= '0;
			randomReg <= WAY_W'(WAYS - 1);
			missAddr <= '0;
		end
		else
		begin
			// Random never lands in a wired way
			if (regWrite && regReg == REG_WIRED)
			begin
				wiredReg <= dataReg[WAY_W-1:0];
				randomReg <= WAY_W'(WAYS - 1);
			end
			else if (randomReg <= wiredReg)
				randomReg <= WAY_W'(WAYS - 1);
			else
				randomReg <= randomReg - 1'b1;

			if (regWrite && regReg == REG_INDEX)
				indexReg <= dataReg[WAY_W-1:0];

			// Software may rearm the capture by writing zero
			if (regWrite && regReg == REG_MISSADDR)
				missAddr <= dataReg[VA_W-1:0];
			else if (missAddr == '0 && missPulse_i)
				missAddr <= missVadr_i;

			if (state == ONE && opReg == OP_ENABLE)
				tlbEnabled <= 1'b1;
			if (state == ONE && opReg == OP_DISABLE)
				tlbEnabled <= 1'b0;

			if (state == ONE && opReg == OP_INVALL)
				validVec <= '0;
			else if (state == TWO && isWrite)
				validVec[entIdx] <= hValid;
		end
	end

	// ====================
	// Holding registers
	// ====================
	always_ff @(posedge clk)
	begin
		if (regWrite)
		begin
			case (regReg)
				REG_VIRTPAGE:
					hVirtPage <= dataReg[VPN_W-1:0];
				REG_PHYSPAGE:
					hPhysPage <= dataReg[PFN_W-1:0];
				REG_MISC:
				begin
					hExec <= dataReg[MISC_X];
					hWrite <= dataReg[MISC_W];
					hRead <= dataReg[MISC_R];
					hUncached <= dataReg[MISC_UNCACHED];
					hGlobal <= dataReg[MISC_GLOBAL];
					hValid <= dataReg[MISC_VALID];
					hAsid <= dataReg[MISC_ASID_LSB +: ASID_W];
				end
				default:
					;
			endcase
		end
		else if (state == TWO && opReg == OP_READ)
		begin
			// Load the selected entry back into the holding registers
			hVirtPage <= {rdTags_i[entIdx.way].tag, entIdx.set};
			hAsid <= rdTags_i[entIdx.way].asid;
			hGlobal <= rdTags_i[entIdx.way].isGlobal;
			hPhysPage <= rdData_i[entIdx.way].pfn;
			hRead <= rdData_i[entIdx.way].rd;
			hWrite <= rdData_i[entIdx.way].wr;
			hExec <= rdData_i[entIdx.way].ex;
			hUncached <= rdData_i[entIdx.way].uncached;
			hValid <= validVec[entIdx];
		end
	end

	// RAM write port
	always_comb
	begin
		entWrEn_o = '0;
		if (state == TWO && isWrite)
			entWrEn_o[entIdx.way] = 1'b1;
	end

	assign entWrSet_o = entIdx.set;
	assign entRdSet_o = entIdx.set;
	assign entWrTag_o = '{tag: hVirtPage[VPN_W-1:SET_W], asid: hAsid, isGlobal: hGlobal};
	assign entWrData_o = '{pfn: hPhysPage, rd: hRead, wr: hWrite, ex: hExec,
		uncached: hUncached};

	// ====================
	// Register readback
	// ====================
	always_comb
	begin
		miscWord = '0;
		miscWord[MISC_X] = hExec;
		miscWord[MISC_W] = hWrite;
		miscWord[MISC_R] = hRead;
		miscWord[MISC_UNCACHED] = hUncached;
		miscWord[MISC_GLOBAL] = hGlobal;
		miscWord[MISC_VALID] = hValid;
		miscWord[MISC_ASID_LSB +: ASID_W] = hAsid;
	end

	always_ff @(posedge clk)
	begin
		case (regReg)
			REG_WIRED:    dataOut_o <= DATA_W'(wiredReg);
			REG_INDEX:    dataOut_o <= DATA_W'(indexReg);
			REG_RANDOM:   dataOut_o <= DATA_W'(randomReg);
			REG_VIRTPAGE: dataOut_o <= DATA_W'(hVirtPage);
			REG_PHYSPAGE: dataOut_o <= DATA_W'(hPhysPage);
			REG_MISC:     dataOut_o <= miscWord;
			REG_MISSADDR: dataOut_o <= DATA_W'(missAddr);
			default:      dataOut_o <= '0;
		endcase
	end

	// Commands are only loaded between sequences
	assert property (@(posedge clk) disable iff (reset_i) ld_i |-> idle_o);

	assert property (@(posedge clk) disable iff (reset_i) randomReg >= wiredReg);

endmodule

/* logic/mmuTop.sv */
`timescale 1ns/1ps

module mmuTop (
	input  logic                          clk,
	input  logic                          reset_i,
	// Translation request
	input  logic                          reqValid_i,
	input  logic [tlbPkg::VA_W-1:0]       vadr_i,
	input  logic                          reqWrite_i,
	input  logic                          reqExec_i,
	input  logic [tlbPkg::ASID_W-1:0]     asid_i,
	input  logic [1:0]                    opLevel_i,
	output logic                          rspValid_o,
	output logic [tlbPkg::PA_W-1:0]       padr_o,
	output logic                          miss_o,
	output logic                          rdViol_o,
	output logic                          wrViol_o,
	output logic                          exViol_o,
	output logic                          uncached_o,
	// Maintenance commands
	input  logic                          ld_i,
	input  mmuRegPkg::tlbOp_t             op_i,
	input  mmuRegPkg::tlbReg_t            regNo_i,
	input  logic [mmuRegPkg::DATA_W-1:0]  dataIn_i,
	output logic                          done_o,
	output logic                          idle_o,
	output logic [mmuRegPkg::DATA_W-1:0]  dataOut_o
);

	import tlbPkg::*;

	logic tlbEnabled;
	logic [ENTRIES-1:0] validVec;
	logic [WAYS-1:0] entWrEn;
	logic [SET_W-1:0] entWrIdx;
	tlbTag_t entWrTag;
	tlbData_t entWrData;
	logic [SET_W-1:0] entRdSet;
	logic [SET_W-1:0] lookupSet;
	tlbTag_t ctlTags [WAYS];
	tlbData_t ctlData [WAYS];
	tlbTag_t lkTags [WAYS];
	tlbData_t lkData [WAYS];
	logic missPulse;
	logic [VA_W-1:0] missVadr;

	tlbControl uControl (
		.clk          (clk),
		.reset_i      (reset_i),
		.ld_i         (ld_i),
		.op_i         (op_i),
		.regNo_i      (regNo_i),
		.dataIn_i     (dataIn_i),
		.done_o       (done_o),
		.idle_o       (idle_o),
		.dataOut_o    (dataOut_o),
		.tlbEnabled_o (tlbEnabled),
		.valid_o      (validVec),
		.entWrEn_o    (entWrEn),
		.entWrSet_o   (entWrIdx),
		.entWrTag_o   (entWrTag),
		.entWrData_o  (entWrData),
		.entRdSet_o   (entRdSet),
		.rdTags_i     (ctlTags),
		.rdData_i     (ctlData),
		.missPulse_i  (missPulse),
		.missVadr_i   (missVadr)
	);

	tlbLookup uLookup (
		.clk          (clk),
		.reset_i      (reset_i),
		.reqValid_i   (reqValid_i),
		.vadr_i       (vadr_i),
		.reqWrite_i   (reqWrite_i),
		.reqExec_i    (reqExec_i),
		.asid_i       (asid_i),
		.opLevel_i    (opLevel_i),
		.tlbEnabled_i (tlbEnabled),
		.valid_i      (validVec),
		.tags_i       (lkTags),
		.data_i       (lkData),
		.lookupSet_o  (lookupSet),
		.rspValid_o   (rspValid_o),
		.padr_o       (padr_o),
		.miss_o       (miss_o),
		.rdViol_o     (rdViol_o),
		.wrViol_o     (wrViol_o),
		.exViol_o     (exViol_o),
		.uncached_o   (uncached_o),
		.missPulse_o  (missPulse),
		.missVadr_o   (missVadr)
	);

	// One tag RAM and one data RAM per way
	for (genvar w = 0; w < WAYS; w++)
	begin : genWay
		tlbEntryRam #(.payload_t(tlbTag_t)) uTagRam (
			.clk       (clk),
			.wrEn_i    (entWrEn[w]),
			.wrSet_i   (entWrIdx),
			.wrData_i  (entWrTag),
			.rdSet0_i  (entRdSet),
			.rdData0_o (ctlTags[w]),
			.rdSet1_i  (lookupSet),
			.rdData1_o (lkTags[w])
		);

		tlbEntryRam #(.payload_t(tlbData_t)) uDataRam (
			.clk       (clk),
			.wrEn_i    (entWrEn[w]),
			.wrSet_i   (entWrIdx),
			.wrData_i  (entWrData),
			.rdSet0_i  (entRdSet),
			.rdData0_o (ctlData[w]),
			.rdSet1_i  (lookupSet),
			.rdData1_o (lkData[w])
		);
	end

endmodule

/* sim/mmuTb.sv */
`timescale 1ns/1ps

module mmuTb;

	import tlbPkg::*;
	import mmuRegPkg::*;

	localparam int CMD_TIMEOUT = 16;

	logic clk;
	logic reset_i;
	logic reqValid;
	logic [VA_W-1:0] vadr;
	logic reqWrite;
	logic reqExec;
	logic [ASID_W-1:0] asid;
	logic [1:0] opLevel;
	logic rspValid;
	logic [PA_W-1:0] padr;
	logic miss;
	logic rdViol;
	logic wrViol;
	logic exViol;
	logic uncached;
	logic ld;
	tlbOp_t opCode;
	tlbReg_t regSel;
	logic [DATA_W-1:0] dataIn;
	logic done;
	logic idle;
	logic [DATA_W-1:0] dataOut;

	// Shadow of the programmed entries at way * SETS + set
	logic shValid [ENTRIES];
	logic [VPN_W-1:0] shVirt [ENTRIES];
	logic [PFN_W-1:0] shPfn [ENTRIES];
	logic [DATA_W-1:0] shMisc [ENTRIES];

	// Software view of the register file
	logic enabled;
	logic [WAY_W-1:0] wiredModel;
	logic [WAY_W-1:0] indexModel;
	logic [VPN_W-1:0] hVirt;
	logic [PFN_W-1:0] hPhys;
	logic [DATA_W-1:0] hMisc;

	// Expected response computed when the request is driven
	logic [PA_W-1:0] expPadr;
	logic expMiss;
	logic expRd;
	logic expWr;
	logic expEx;
	logic expUnc;
	logic chkValid;
	logic [PA_W-1:0] chkPadr;
	logic chkMiss;
	logic chkRd;
	logic chkWr;
	logic chkEx;
	logic chkUnc;

	int seed;
	logic [VPN_W-1:0] hitPages [$];

	mmuTop u_dut (
		.clk        (clk),
		.reset_i    (reset_i),
		.reqValid_i (reqValid),
		.vadr_i     (vadr),
		.reqWrite_i (reqWrite),
		.reqExec_i  (reqExec),
		.asid_i     (asid),
		.opLevel_i  (opLevel),
		.rspValid_o (rspValid),
		.padr_o     (padr),
		.miss_o     (miss),
		.rdViol_o   (rdViol),
		.wrViol_o   (wrViol),
		.exViol_o   (exViol),
		.uncached_o (uncached),
		.ld_i       (ld),
		.op_i       (opCode),
		.regNo_i    (regSel),
		.dataIn_i   (dataIn),
		.done_o     (done),
		.idle_o     (idle),
		.dataOut_o  (dataOut)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic stopOnError(input string why);
		$display("%s", why);
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic mismatch(input string name, input logic [31:0] got, input logic [31:0] exp);
		stopOnError($sformatf("MISMATCH %s got=%h expected=%h", name, got, exp));
	endtask

	// ====================
	// Response checks
	// ====================
	always @(posedge clk)
	begin
		if (reset_i)
			chkValid <= 1'b0;
		else
			chkValid <= reqValid;
		chkPadr <= expPadr;
		chkMiss <= expMiss;
		chkRd <= expRd;
		chkWr <= expWr;
		chkEx <= expEx;
		chkUnc <= expUnc;
	end

	assert property (@(posedge clk) disable iff (reset_i) rspValid == chkValid)
		else mismatch("rspValid_o", $sampled(rspValid), $sampled(chkValid));
	assert property (@(posedge clk) disable iff (reset_i) chkValid |-> padr == chkPadr)
		else mismatch("padr_o", $sampled(padr), $sampled(chkPadr));
	assert property (@(posedge clk) disable iff (reset_i) chkValid |-> miss == chkMiss)
		else mismatch("miss_o", $sampled(miss), $sampled(chkMiss));
	assert property (@(posedge clk) disable iff (reset_i) chkValid |-> rdViol == chkRd)
		else mismatch("rdViol_o", $sampled(rdViol), $sampled(chkRd));
	assert property (@(posedge clk) disable iff (reset_i) chkValid |-> wrViol == chkWr)
		else mismatch("wrViol_o", $sampled(wrViol), $sampled(chkWr));
	assert property (@(posedge clk) disable iff (reset_i) chkValid |-> exViol == chkEx)
		else mismatch("exViol_o", $sampled(exViol), $sampled(chkEx));
	assert property (@(posedge clk) disable iff (reset_i) chkValid |-> uncached == chkUnc)
		else mismatch("uncached_o", $sampled(uncached), $sampled(chkUnc));

	// Done follows a load by exactly two cycles and lasts one
	assert property (@(posedge clk) disable iff (reset_i) done == $past(ld, 2))
		else mismatch("done_o", $sampled(done), !$sampled(done));

	function automatic logic [OFFSET_W-1:0] randomOffset();
		logic [31:0] r;
		r = $random(seed);
		return r[OFFSET_W-1:0];
	endfunction

	// Top tag bit stays low so the page never falls into the unmapped region
	function automatic logic [TAG_W-1:0] randomTag();
		logic [31:0] r;
		r = $random(seed);
		r[TAG_W-1] = 1'b0;
		return r[TAG_W-1:0];
	endfunction

	function automatic logic [DATA_W-1:0] makeMisc(input logic v, input logic r, input logic w,
		input logic x, input logic unc, input logic glob, input logic [ASID_W-1:0] id);
		logic [DATA_W-1:0] m;
		m = '0;
		m[MISC_VALID] = v;
		m[MISC_R] = r;
		m[MISC_W] = w;
		m[MISC_X] = x;
		m[MISC_UNCACHED] = unc;
		m[MISC_GLOBAL] = glob;
		m[MISC_ASID_LSB +: ASID_W] = id;
		return m;
	endfunction

	// Expected translation from the shadow entries
	task automatic predict(input logic [VA_W-1:0] va, input logic wr, input logic ex);
		logic [SET_W-1:0] set;
		logic [TAG_W-1:0] tag;
		int e;
		int hitEntry;
		set = va[OFFSET_W +: SET_W];
		tag = va[VA_W-1 -: TAG_W];
		hitEntry = -1;
		expPadr = va;
		expMiss = 1'b0;
		expRd = 1'b0;
		expWr = 1'b0;
		expEx = 1'b0;
		expUnc = 1'b0;
		if (enabled && opLevel != 2'd0 && va[VA_W-1 -: 8] != 8'hFF)
		begin
			for (int w = WAYS - 1; w >= 0; w--)
			begin
				e = w * SETS + set;
				if (shValid[e] && shVirt[e][VPN_W-1:SET_W] == tag
					&& (shMisc[e][MISC_ASID_LSB +: ASID_W] == asid || shMisc[e][MISC_GLOBAL]))
					hitEntry = e;
			end
			if (hitEntry < 0)
			begin
				expPadr = {MISS_PFN, va[OFFSET_W-1:0]};
				expMiss = 1'b1;
			end
			else
			begin
				expPadr = {shPfn[hitEntry], va[OFFSET_W-1:0]};
				expWr = wr && !shMisc[hitEntry][MISC_W];
				expEx = ex && !shMisc[hitEntry][MISC_X];
				expRd = !wr && !ex && !shMisc[hitEntry][MISC_R];
				expUnc = shMisc[hitEntry][MISC_UNCACHED];
			end
		end
	endtask

	task automatic translate(input logic [VA_W-1:0] va, input logic wr, input logic ex);
		@(negedge clk);
		reqValid = 1'b1;
		vadr = va;
		reqWrite = wr;
		reqExec = ex;
		predict(va, wr, ex);
	endtask

	task automatic endRequests();
		@(negedge clk);
		reqValid = 1'b0;
		reqWrite = 1'b0;
		reqExec = 1'b0;
	endtask

	// ====================
	// Command tasks
	// ====================
	task automatic command(input tlbOp_t op, input tlbReg_t regNo, input logic [DATA_W-1:0] data);
		int waitCycles;
		@(negedge clk);
		ld = 1'b1;
		opCode = op;
		regSel = regNo;
		dataIn = data;
		@(negedge clk);
		ld = 1'b0;
		opCode = OP_NOP;
		waitCycles = 0;
		while (!done)
		begin
			if (waitCycles == CMD_TIMEOUT)
				stopOnError("Timed out waiting for done_o after a command load");
			@(negedge clk);
			waitCycles++;
		end
		// Writes land and dataOut_o settles one cycle after done
		@(negedge clk);
	endtask

	task automatic setReg(input tlbReg_t regNo, input logic [DATA_W-1:0] value);
		command(OP_WRREG, regNo, value);
		case (regNo)
			REG_WIRED:    wiredModel = value[WAY_W-1:0];
			REG_INDEX:    indexModel = value[WAY_W-1:0];
			REG_VIRTPAGE: hVirt = value[VPN_W-1:0];
			REG_PHYSPAGE: hPhys = value[PFN_W-1:0];
			REG_MISC:     hMisc = value;
			default:      ;
		endcase
	endtask

	task automatic checkReg(input tlbReg_t regNo, input logic [DATA_W-1:0] expected);
		command(OP_RDREG, regNo, '0);
		assert (dataOut == expected)
			else mismatch($sformatf("dataOut_o(%s)", regNo.name()), dataOut, expected);
	endtask

	task automatic loadHolding(input logic [VPN_W-1:0] vpn, input logic [PFN_W-1:0] pfn,
		input logic [DATA_W-1:0] misc);
		setReg(REG_VIRTPAGE, DATA_W'(vpn));
		setReg(REG_PHYSPAGE, DATA_W'(pfn));
		setReg(REG_MISC, misc);
	endtask

	task automatic storeShadow(input int e);
		shValid[e] = hMisc[MISC_VALID];
		shVirt[e] = hVirt;
		shPfn[e] = hPhys;
		shMisc[e] = hMisc;
	endtask

	task automatic writeIndexed(input int way);
		setReg(REG_INDEX, DATA_W'(way));
		command(OP_WRITE_IDX, REG_INDEX, '0);
		storeShadow(indexModel * SETS + hVirt[SET_W-1:0]);
	endtask

	// Shadow drops the replaceable ways of the set and keeps the new entry in the first of them
	task automatic writeRandom();
		int set;
		command(OP_WRITE_RND, REG_RANDOM, '0);
		set = hVirt[SET_W-1:0];
		for (int w = wiredModel; w < WAYS; w++)
			shValid[w * SETS + set] = 1'b0;
		storeShadow(wiredModel * SETS + set);
	endtask

	initial
	begin
		logic [VPN_W-1:0] vpnA;
		logic [VPN_W-1:0] vpnB;
		logic [VPN_W-1:0] vpnR;
		logic [VPN_W-1:0] vpnW;
		logic [VPN_W-1:0] vpnX;
		logic [VPN_W-1:0] vpnWired;
		logic [TAG_W-1:0] tagBase;
		logic [PFN_W-1:0] pfnA;
		logic [DATA_W-1:0] miscA;
		logic [VA_W-1:0] firstMiss;
		logic [31:0] r;

		seed = 32'h5603777f;
		reset_i = 1'b1;
		reqValid = 1'b0;
		vadr = '0;
		reqWrite = 1'b0;
		reqExec = 1'b0;
		asid = '0;
		opLevel = 2'd0;
		ld = 1'b0;
		opCode = OP_NOP;
		regSel = REG_WIRED;
		dataIn = '0;
		enabled = 1'b0;
		wiredModel = '0;
		indexModel = '0;
		hVirt = '0;
		hPhys = '0;
		hMisc = '0;
		for (int i = 0; i < ENTRIES; i++)
			shValid[i] = 1'b0;
		predict('0, 1'b0, 1'b0);

		repeat (10) @(posedge clk);
		@(negedge clk);
		reset_i = 1'b0;

		// ====================
		// Reset and identity
		// ====================
		assert (!done && idle && !rspValid && !miss && !rdViol && !wrViol && !exViol)
			else stopOnError("Outputs are not at their reset values after reset");
		checkReg(REG_WIRED, '0);
		checkReg(REG_MISSADDR, '0);
		opLevel = 2'd1;
		asid = 8'h11;
		for (int i = 0; i < 8; i++)
		begin
			r = $random(seed);
			translate(r, r[0], r[1]);
		end
		endRequests();
		command(OP_ENABLE, REG_WIRED, '0);
		enabled = 1'b1;
		opLevel = 2'd0;
		for (int i = 0; i < 6; i++)
			translate($random(seed), 1'b0, 1'b0);
		endRequests();
		opLevel = 2'd2;
		for (int i = 0; i < 6; i++)
		begin
			r = $random(seed);
			translate({8'hFF, r[23:0]}, 1'b0, 1'b0);
		end
		endRequests();
		opLevel = 2'd1;

		// Indexed write of one uncached and one cached page
		vpnA = {randomTag(), 4'd3};
		r = $random(seed);
		pfnA = r[PFN_W-1:0];
		miscA = makeMisc(1'b1, 1'b1, 1'b1, 1'b0, 1'b1, 1'b0, 8'h11);
		loadHolding(vpnA, pfnA, miscA);
		writeIndexed(2);
		vpnB = {randomTag(), 4'd4};
		loadHolding(vpnB, PFN_W'($random(seed)),
			makeMisc(1'b1, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 8'h11));
		writeIndexed(1);
		hitPages.push_back(vpnA);
		hitPages.push_back(vpnB);
		for (int i = 0; i < 8; i++)
		begin
			r = $random(seed);
			translate({vpnA, randomOffset()}, r[0], 1'b0);
			translate({vpnB, randomOffset()}, r[1], 1'b0);
		end
		endRequests();

		// Scramble the holding registers and read the entry back
		loadHolding('0, '0, '0);
		setReg(REG_VIRTPAGE, DATA_W'(vpnA));
		setReg(REG_INDEX, 32'd2);
		command(OP_READ, REG_INDEX, '0);
		checkReg(REG_VIRTPAGE, DATA_W'(vpnA));
		checkReg(REG_PHYSPAGE, DATA_W'(pfnA));
		checkReg(REG_MISC, miscA);

		// ====================
		// Miss and miss address
		// ====================
		firstMiss = {randomTag(), 4'd12, randomOffset()};
		translate(firstMiss, 1'b0, 1'b0);
		endRequests();
		checkReg(REG_MISSADDR, firstMiss);
		translate({randomTag(), 4'd13, randomOffset()}, 1'b1, 1'b0);
		endRequests();
		checkReg(REG_MISSADDR, firstMiss);

		// ====================
		// Permissions and ASID
		// ====================
		vpnR = {randomTag(), 4'd5};
		loadHolding(vpnR, PFN_W'($random(seed)),
			makeMisc(1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 8'h11));
		writeIndexed(0);
		vpnW = {randomTag(), 4'd6};
		loadHolding(vpnW, PFN_W'($random(seed)),
			makeMisc(1'b1, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1, 8'h22));
		writeIndexed(0);
		vpnX = {randomTag(), 4'd7};
		loadHolding(vpnX, PFN_W'($random(seed)),
			makeMisc(1'b1, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 8'h11));
		writeIndexed(3);
		hitPages.push_back(vpnR);
		hitPages.push_back(vpnW);
		hitPages.push_back(vpnX);
		for (int p = 0; p < 3; p++)
		begin
			translate({hitPages[2 + p], randomOffset()}, 1'b0, 1'b0);
			translate({hitPages[2 + p], randomOffset()}, 1'b1, 1'b0);
			translate({hitPages[2 + p], randomOffset()}, 1'b0, 1'b1);
		end
		endRequests();
		asid = 8'h33;
		translate({vpnR, randomOffset()}, 1'b0, 1'b0);
		translate({vpnW, randomOffset()}, 1'b1, 1'b0);
		translate({vpnW, randomOffset()}, 1'b0, 1'b0);
		endRequests();
		asid = 8'h11;

		// ====================
		// Wired and random
		// ====================
		setReg(REG_WIRED, 32'd1);
		checkReg(REG_WIRED, 32'd1);
		tagBase = randomTag();
		vpnWired = {tagBase, 4'd9};
		loadHolding(vpnWired, PFN_W'($random(seed)),
			makeMisc(1'b1, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 8'h11));
		writeIndexed(0);
		hitPages.push_back(vpnWired);
		for (int i = 1; i <= 10; i++)
		begin
			vpnR = {tagBase ^ TAG_W'(i), 4'd9};
			loadHolding(vpnR, PFN_W'($random(seed)),
				makeMisc(1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 8'h11));
			writeRandom();
			translate({vpnR, randomOffset()}, 1'b0, 1'b0);
			translate({vpnWired, randomOffset()}, 1'b1, 1'b0);
			endRequests();
		end

		// ====================
		// Invalidate and disable
		// ====================
		command(OP_INVALL, REG_WIRED, '0);
		for (int i = 0; i < ENTRIES; i++)
			shValid[i] = 1'b0;
		foreach (hitPages[i])
			translate({hitPages[i], randomOffset()}, 1'b0, 1'b0);
		endRequests();
		command(OP_DISABLE, REG_WIRED, '0);
		enabled = 1'b0;
		foreach (hitPages[i])
			translate({hitPages[i], randomOffset()}, 1'b0, 1'b1);
		endRequests();
		checkReg(REG_MISSADDR, firstMiss);

		@(negedge clk);
		$display("Test completed successfully");
		$finish;
	end

endmodule

/* mmuTop.f */
common/tlbPkg.sv
common/mmuRegPkg.sv
tlb/tlbEntryRam.sv
tlb/tlbLookup.sv
tlb/tlbControl.sv
logic/mmuTop.sv
sim/mmuTb.sv

/* Bender.yml */
package:
  name: mmuTop

sources:
  # Shared packages
  - files:
      - common/tlbPkg.sv
      - common/mmuRegPkg.sv
  # RTL
  - files:
      - tlb/tlbEntryRam.sv
      - tlb/tlbLookup.sv
      - tlb/tlbControl.sv
      - logic/mmuTop.sv
  # Testbench
  - target: simulation
    files:
      - sim/mmuTb.sv
